//--- ecc_cfg.svh
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

////////////////////////////////////////
// SEC-DED (72,64) code dimensions
////////////////////////////////////////

// Payload word carried by one codeword
`define ECC_DATA_BITS 64

// Full codeword, overall parity at bit 0
`define ECC_CODE_BITS 72

// Index into the codeword, 0 to 71
`define ECC_POS_BITS 7

// Hamming check bits at positions 1, 2, 4 .. 64
`define ECC_CHK_BITS 7

// Saturating event counters
`define ECC_CNT_BITS 16

`endif

//--- ecc_pkg.sv
`include "ecc_cfg.svh"

package ecc_pkg;

	////////////////////////////////////////
	// Code word types
	////////////////////////////////////////

	// Plain data word on both ends of the path
	typedef logic [`ECC_DATA_BITS-1:0] data_t;

	// Protected word
	// Bit 0 overall parity
	// Power-of-two positions hold the Hamming check bits
	// All other positions carry data, lowest data bit first
	typedef logic [`ECC_CODE_BITS-1:0] codeword_t;

	////////////////////////////////////////
	// Indexing and syndrome
	////////////////////////////////////////

	// Bit index inside a codeword
	typedef logic [`ECC_POS_BITS-1:0] bit_pos_t;

	// One bit per Hamming check bit
	// Nonzero value points at the failing position
	typedef logic [`ECC_CHK_BITS-1:0] syndrome_t;

endpackage

//--- ecc_ctrl_pkg.sv
`include "ecc_cfg.svh"

package ecc_ctrl_pkg;

	import ecc_pkg::*;

	////////////////////////////////////////
	// Fault injection command
	////////////////////////////////////////

	// num_bits 0 leaves the word alone
	// 1 flips pos0, 2 flips pos0 and pos1
	typedef struct packed {
		logic [1:0] num_bits;
		bit_pos_t   pos0;
		bit_pos_t   pos1;
	} inj_cmd_t;

	////////////////////////////////////////
	// Decoder result and counters
	////////////////////////////////////////

	// Never both set for the same word
	typedef struct packed {
		logic correctable;
		logic uncorrectable;
	} dec_status_t;

	// Sticks at all ones
	typedef logic [`ECC_CNT_BITS-1:0] err_count_t;

endpackage

//--- hamming_encoder.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module hamming_encoder import ecc_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  data_t     data_in,
	input  logic      valid_in,
	output codeword_t data_out,
	output logic      valid_out
);

	////////////////////////////////////////
	// Codeword build
	////////////////////////////////////////

	codeword_t code;

	always_comb begin
		int  d;
		logic p;
		code = '0;
		d = 0;
		// Scatter data over the non-power-of-two slots
		for (int i = 1; i < `ECC_CODE_BITS; i++) begin
			if ((i & (i - 1)) != 0) begin
				code[i] = data_in[d];
				d++;
			end
		end
		// Check bit k is parity over every index with bit k set
		// Its own slot is still zero here
		for (int k = 0; k < `ECC_CHK_BITS; k++) begin
			p = 1'b0;
			for (int i = 1; i < `ECC_CODE_BITS; i++) begin
				if (i[k])
					p ^= code[i];
			end
			code[1 << k] = p;
		end
		// Overall parity makes the full word even
		code[0] = ^code[`ECC_CODE_BITS-1:1];
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		data_out <= code;
	end

endmodule

//--- error_injector.sv
`timescale 1ns/1ps

module error_injector import ecc_pkg::*, ecc_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  codeword_t code_in,
	input  logic      valid_in,
	input  inj_cmd_t  inj,
	output codeword_t code_out,
	output logic      valid_out
);

	////////////////////////////////////////
	// Flip mask
	////////////////////////////////////////

	codeword_t flip;

	// Command is already screened by the control block
	always_comb begin
		flip = '0;
		if (inj.num_bits >= 2'd1)
			flip[inj.pos0] = 1'b1;
		if (inj.num_bits == 2'd2)
			flip[inj.pos1] = 1'b1;
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// Corrupted copy of the incoming word
	always_ff @(posedge clk) begin
		code_out <= code_in ^ flip;
	end

endmodule

//--- hamming_decoder.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module hamming_decoder import ecc_pkg::*, ecc_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  codeword_t   code_in,
	input  logic        valid_in,
	output data_t       data_out,
	output logic        valid_out,
	output dec_status_t status
);

	////////////////////////////////////////
	// Syndrome and parity
	////////////////////////////////////////

	syndrome_t syndrome;
	logic      parity_odd;

	always_comb begin
		// Each syndrome bit rechecks one check group, check bit included
		for (int k = 0; k < `ECC_CHK_BITS; k++) begin
			syndrome[k] = 1'b0;
			for (int i = 1; i < `ECC_CODE_BITS; i++) begin
				if (i[k])
					syndrome[k] ^= code_in[i];
			end
		end
		parity_odd = ^code_in;
	end

	////////////////////////////////////////
	// Classify, correct, extract
	////////////////////////////////////////

	codeword_t   fixed;
	data_t       data_d;
	dec_status_t status_d;

	always_comb begin
		int d;
		fixed = code_in;
		status_d = '0;
		if (parity_odd) begin
			if (syndrome == '0) begin
				// Only bit 0 hit, data untouched
				status_d.correctable = 1'b1;
			end else if (syndrome < `ECC_CODE_BITS) begin
				fixed[syndrome] = ~code_in[syndrome];
				status_d.correctable = 1'b1;
			end else begin
				// Points past the word, cannot be a single flip
				status_d.uncorrectable = 1'b1;
			end
		end else if (syndrome != '0) begin
			// Even parity with a syndrome means two flips
			status_d.uncorrectable = 1'b1;
		end
		// Gather data from the non-power-of-two slots
		d = 0;
		data_d = '0;
		for (int i = 1; i < `ECC_CODE_BITS; i++) begin
			if ((i & (i - 1)) != 0) begin
				data_d[d] = fixed[i];
				d++;
			end
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out <= 1'b0;
			status    <= '0;
		end else begin
			valid_out <= valid_in;
			// Status only speaks for a valid word
			status    <= valid_in ? status_d : '0;
		end
	end

	always_ff @(posedge clk) begin
		data_out <= data_d;
	end

endmodule

//--- ecc_inject_ctrl.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_inject_ctrl import ecc_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        inj_wr,
	input  inj_cmd_t    inj_cmd,
	output inj_cmd_t    inj_active,
	input  logic        dec_valid,
	input  dec_status_t dec_status,
	input  logic        cnt_clr,
	output err_count_t  corr_count,
	output err_count_t  uncorr_count
);

	////////////////////////////////////////
	// Command screening
	////////////////////////////////////////

	logic cmd_legal;

	// Only positions actually flipped are range checked
	always_comb begin
		case (inj_cmd.num_bits)
			2'd0: cmd_legal = 1'b1;
			2'd1: cmd_legal = inj_cmd.pos0 < `ECC_CODE_BITS;
			2'd2: cmd_legal = (inj_cmd.pos0 < `ECC_CODE_BITS) &&
				(inj_cmd.pos1 < `ECC_CODE_BITS) && (inj_cmd.pos0 != inj_cmd.pos1);
			default: cmd_legal = 1'b0;
		endcase
	end

	// Illegal writes are dropped, last good setting stays
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inj_active <= '0;
		end else if (inj_wr && cmd_legal) begin
			inj_active <= inj_cmd;
		end
	end

	////////////////////////////////////////
	// Event counters
	////////////////////////////////////////

	function automatic err_count_t sat_inc(err_count_t cnt, logic hit);
		if (hit && cnt != '1)
			return cnt + 1'b1;
		return cnt;
	endfunction

	// Clear wins over a same-cycle event
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			corr_count   <= '0;
			uncorr_count <= '0;
		end else if (cnt_clr) begin
			corr_count   <= '0;
			uncorr_count <= '0;
		end else begin
			corr_count   <= sat_inc(corr_count, dec_valid && dec_status.correctable);
			uncorr_count <= sat_inc(uncorr_count, dec_valid && dec_status.uncorrectable);
		end
	end

endmodule

//--- ecc_top.sv
`timescale 1ns/1ps

module ecc_top import ecc_pkg::*, ecc_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  data_t       plaintext,
	input  logic        plaintext_valid,
	input  logic        inj_wr,
	input  inj_cmd_t    inj_cmd,
	input  logic        cnt_clr,
	output data_t       decoded,
	output logic        decoded_valid,
	output dec_status_t status,
	output err_count_t  corr_count,
	output err_count_t  uncorr_count
);

	////////////////////////////////////////
	// Datapath, three register stages
	////////////////////////////////////////

	codeword_t codeword;
	logic      codeword_valid;
	codeword_t corrupted;
	logic      corrupted_valid;
	inj_cmd_t  inj_active;

	hamming_encoder i_encoder (
		.clk       (clk),
		.arst_n    (arst_n),
		.data_in   (plaintext),
		.valid_in  (plaintext_valid),
		.data_out  (codeword),
		.valid_out (codeword_valid)
	);

	// Fault point between encoder and decoder
	error_injector i_injector (
		.clk       (clk),
		.arst_n    (arst_n),
		.code_in   (codeword),
		.valid_in  (codeword_valid),
		.inj       (inj_active),
		.code_out  (corrupted),
		.valid_out (corrupted_valid)
	);

	hamming_decoder i_decoder (
		.clk       (clk),
		.arst_n    (arst_n),
		.code_in   (corrupted),
		.valid_in  (corrupted_valid),
		.data_out  (decoded),
		.valid_out (decoded_valid),
		.status    (status)
	);

	////////////////////////////////////////
	// Injection control and statistics
	////////////////////////////////////////

	ecc_inject_ctrl i_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.inj_wr       (inj_wr),
		.inj_cmd      (inj_cmd),
		.inj_active   (inj_active),
		.dec_valid    (decoded_valid),
		.dec_status   (status),
		.cnt_clr      (cnt_clr),
		.corr_count   (corr_count),
		.uncorr_count (uncorr_count)
	);

endmodule

//--- ecc_checker.sv
`timescale 1ns/1ps

module ecc_checker import ecc_ctrl_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        plaintext_valid,
	input logic        decoded_valid,
	input dec_status_t status,
	input err_count_t  corr_count,
	input err_count_t  uncorr_count
);

	////////////////////////////////////////
	// Status and pipeline properties
	////////////////////////////////////////

	// A word is either fixed or lost, never both
	a_status_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(status.correctable && status.uncorrectable))
		else $error("correctable and uncorrectable set together");

	// Three register stages from plaintext to decoded
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		decoded_valid == $past(plaintext_valid, 3))
		else $error("decoded_valid does not follow plaintext_valid by 3 cycles");

	// Everything quiet while reset is held
	a_reset: assert property (@(posedge clk)
		!arst_n |-> (!decoded_valid && status == '0 && corr_count == '0 &&
		uncorr_count == '0))
		else $error("outputs not cleared during reset");

endmodule

bind ecc_top ecc_checker i_checker (
	.clk             (clk),
	.arst_n          (arst_n),
	.plaintext_valid (plaintext_valid),
	.decoded_valid   (decoded_valid),
	.status          (status),
	.corr_count      (corr_count),
	.uncorr_count    (uncorr_count)
);

//--- tb_ecc_top.sv
`timescale 1ns/1ps

module tb_ecc_top import ecc_pkg::*, ecc_ctrl_pkg::*; ();

	////////////////////////////////////////
	// DUT signals and types
	////////////////////////////////////////

	logic        clk;
	logic        arst_n;
	data_t       plaintext;
	logic        plaintext_valid;
	logic        inj_wr;
	inj_cmd_t    inj_cmd;
	logic        cnt_clr;
	data_t       decoded;
	logic        decoded_valid;
	dec_status_t status;
	err_count_t  corr_count;
	err_count_t  uncorr_count;

	// One table row with command, legality and word count
	typedef struct packed {
		inj_cmd_t   cmd;
		logic       legal;
		logic [7:0] reps;
	} entry_t;

	// One word in flight with its expected result
	typedef struct packed {
		data_t       data;
		dec_status_t status;
		logic        cmp_data;
		logic        last;
		logic [7:0]  idx;
	} exp_word_t;

	entry_t      table_q[$];
	exp_word_t   exp_q[$];
	exp_word_t   rx;
	logic [63:0] lcg_state;
	inj_cmd_t    model;
	int          n_checks;
	int          n_errors;
	int          errs_at_entry;
	int          exp_corr;
	int          exp_uncorr;

	ecc_top i_dut (.*);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [63:0] lcg_next(input logic [63:0] s);
		return s * 64'd6364136223846793005 + 64'd1442695040888963407;
	endfunction

	// Zero, one or two flips map straight onto the status flags
	function automatic dec_status_t expected_status(input inj_cmd_t c);
		dec_status_t s;
		s = '0;
		s.correctable = (c.num_bits == 2'd1);
		s.uncorrectable = (c.num_bits == 2'd2);
		return s;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input logic [1:0] nb, input int p0, input int p1,
		input logic legal, input int reps);
		entry_t e;
		e.cmd.num_bits = nb;
		e.cmd.pos0 = bit_pos_t'(p0);
		e.cmd.pos1 = bit_pos_t'(p1);
		e.legal = legal;
		e.reps = 8'(reps);
		table_q.push_back(e);
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic load_table();
		add_entry(2'd0, 0, 0, 1'b1, 6);
		// Single flips on data, check and parity bits
		add_entry(2'd1, 5, 0, 1'b1, 4);
		add_entry(2'd1, 8, 0, 1'b1, 3);
		add_entry(2'd1, 0, 0, 1'b1, 3);
		add_entry(2'd1, 71, 0, 1'b1, 3);
		add_entry(2'd2, 3, 40, 1'b1, 4);
		// Rejected command keeps the double flip in force
		add_entry(2'd3, 1, 2, 1'b0, 3);
		add_entry(2'd1, 64, 0, 1'b1, 2);
		// Out of range position is rejected
		add_entry(2'd1, 72, 0, 1'b0, 3);
		add_entry(2'd2, 0, 70, 1'b1, 3);
		// Equal positions are rejected and the double flip stays
		add_entry(2'd2, 9, 9, 1'b0, 3);
		// One word per setting so changes land while words are in flight
		add_entry(2'd1, 2, 0, 1'b1, 1);
		add_entry(2'd2, 1, 2, 1'b1, 1);
		add_entry(2'd0, 0, 0, 1'b1, 2);
		add_entry(2'd1, 33, 0, 1'b1, 1);
	endtask

	////////////////////////////////////////
	// Clock, stimulus and final checks
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		exp_word_t ex;
		arst_n = 1'b0;
		plaintext = '0;
		plaintext_valid = 1'b0;
		inj_wr = 1'b0;
		inj_cmd = '0;
		cnt_clr = 1'b0;
		lcg_state = 64'd66;
		model = '0;
		load_table();
		repeat (8) @(posedge clk);
		#10 arst_n = 1'b1;
		for (int e = 0; e < table_q.size(); e++) begin
			// Write lands with the first word and already applies to it
			if (table_q[e].legal)
				model = table_q[e].cmd;
			for (int r = 0; r < int'(table_q[e].reps); r++) begin
				@(posedge clk);
				#10;
				inj_wr = (r == 0);
				inj_cmd = table_q[e].cmd;
				lcg_state = lcg_next(lcg_state);
				plaintext = lcg_state;
				plaintext_valid = 1'b1;
				ex.data = lcg_state;
				ex.status = expected_status(model);
				ex.cmp_data = (model.num_bits != 2'd2);
				ex.last = (r == int'(table_q[e].reps) - 1);
				ex.idx = 8'(e);
				exp_q.push_back(ex);
				exp_corr += int'(ex.status.correctable);
				exp_uncorr += int'(ex.status.uncorrectable);
			end
		end
		@(posedge clk);
		#10;
		plaintext_valid = 1'b0;
		inj_wr = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#10;
		check_value(64'(corr_count), 64'(exp_corr), "corr_count");
		check_value(64'(uncorr_count), 64'(exp_uncorr), "uncorr_count");
		cnt_clr = 1'b1;
		@(posedge clk);
		#10 cnt_clr = 1'b0;
		check_value(64'(corr_count), 64'd0, "corr_count after clear");
		check_value(64'(uncorr_count), 64'd0, "uncorr_count after clear");
		$display("counters: expected %0d correctable, %0d uncorrectable, clear done",
			exp_corr, exp_uncorr);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Scoreboard pops one expected word per decoded word
	always @(negedge clk) begin
		if (arst_n && decoded_valid) begin
			if (exp_q.size() == 0) begin
				n_errors++;
				$display("Decoder produced a word while none was pending");
			end else begin
				rx = exp_q.pop_front();
				check_value(64'(status), 64'(rx.status), "status");
				if (rx.cmp_data)
					check_value(decoded, rx.data, "decoded data");
				if (rx.last) begin
					$display("entry %0d nb=%0d pos0=%0d pos1=%0d legal=%0d: %0d errors",
						rx.idx, table_q[rx.idx].cmd.num_bits, table_q[rx.idx].cmd.pos0,
						table_q[rx.idx].cmd.pos1, table_q[rx.idx].legal,
						n_errors - errs_at_entry);
					errs_at_entry = n_errors;
				end
			end
		end
	end

	// Watchdog sized from the table
	initial begin
		int limit;
		int max_reps;
		#1;
		max_reps = 0;
		foreach (table_q[i])
			if (int'(table_q[i].reps) > max_reps)
				max_reps = int'(table_q[i].reps);
		limit = table_q.size() * max_reps * 4 + 40;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles with %0d words still pending", limit, exp_q.size());
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
ecc_pkg.sv
ecc_ctrl_pkg.sv
hamming_encoder.sv
error_injector.sv
hamming_decoder.sv
ecc_inject_ctrl.sv
ecc_top.sv
ecc_checker.sv
tb_ecc_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ECC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ecc_top \
	-f verilog.f -o sim_ecc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_ecc 2>&1)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
	echo "Simulation exited with status $rc"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
